// File: design/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// First opcode fetch after reset
`define CPU_RESET_PC    16'h0200

// Supported opcode bytes
`define CPU_OP_LDA_IMM  8'hA9
`define CPU_OP_LDX_IMM  8'hA2
`define CPU_OP_ADC_IMM  8'h69
`define CPU_OP_AND_IMM  8'h29
`define CPU_OP_ORA_IMM  8'h09
`define CPU_OP_EOR_IMM  8'h49
`define CPU_OP_LSR_A    8'h4A
`define CPU_OP_TAX      8'hAA
`define CPU_OP_TXA      8'h8A
`define CPU_OP_CLC      8'h18
`define CPU_OP_SEC      8'h38
`define CPU_OP_NOP      8'hEA
`define CPU_OP_LDA_ABS  8'hAD
`define CPU_OP_STA_ABS  8'h8D
`define CPU_OP_STX_ABS  8'h8E
`define CPU_OP_JMP_ABS  8'h4C

`endif

// File: design/cpu_bus_pkg.sv
`default_nettype none

package cpu_bus_pkg;

    // One byte on the memory or internal data bus
    typedef logic [7:0] data_t;

    // Memory address
    typedef logic [15:0] addr_t;

endpackage

`default_nettype wire

// File: design/cpu_ctrl_pkg.sv
`default_nettype none

package cpu_ctrl_pkg;

    // Timing states, T0 is the opcode fetch
    typedef enum logic [1:0] {
        TCU_T0, TCU_T1, TCU_T2, TCU_T3
    } tcu_e;

    // Data bus sources
    typedef enum logic [1:0] {
        DB_DL, DB_AC, DB_X, DB_ALU
    } db_src_e;

    // Next address source
    typedef enum logic [1:0] {
        ADR_PC, ADR_OP, ADR_HOLD
    } adr_src_e;

    typedef enum logic [2:0] {
        ALU_PASS, ALU_SUM, ALU_AND, ALU_EOR, ALU_OR, ALU_SR
    } alu_op_e;

endpackage

`default_nettype wire

// File: design/cpu_timing.sv
`timescale 1ns/1ns
`default_nettype none
`include "cpu_settings.svh"

module cpu_timing
    import cpu_bus_pkg::*, cpu_ctrl_pkg::*;
(
    input  logic  i_clk,
    input  logic  i_rst_n,
    input  data_t i_data,
    input  tcu_e  i_tcu_next,
    output tcu_e  o_tcu,
    output data_t o_ir,
    output logic  o_sync
);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_tcu  <= TCU_T0;
            o_ir   <= `CPU_OP_NOP;
            o_sync <= 1'b1;
        end else begin
            o_tcu  <= i_tcu_next;
            // Sync marks the cycle that starts with the next fetch
            o_sync <= (i_tcu_next == TCU_T0);
            // Opcode byte is on the bus during T0
            if (o_tcu == TCU_T0) begin
                o_ir <= i_data;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/cpu_decoder.sv
`timescale 1ns/1ns
`default_nettype none
`include "cpu_settings.svh"

module cpu_decoder
    import cpu_bus_pkg::*, cpu_ctrl_pkg::*;
(
    input  data_t    i_ir,
    input  tcu_e     i_tcu,
    output tcu_e     o_tcu_next,
    output db_src_e  o_db_src,
    output alu_op_e  o_alu_op,
    output adr_src_e o_adr_src,
    output logic     o_pc_inc,
    output logic     o_pc_jump,
    output logic     o_ld_ac,
    output logic     o_ld_x,
    output logic     o_ld_opl,
    output logic     o_upd_nz,
    output logic     o_upd_c,
    output logic     o_set_c,
    output logic     o_clr_c,
    output logic     o_rw_next
);

    always_comb begin
        o_tcu_next = TCU_T0;
        o_db_src   = DB_DL;
        o_alu_op   = ALU_PASS;
        o_adr_src  = ADR_PC;
        o_pc_inc   = 1'b0;
        o_pc_jump  = 1'b0;
        o_ld_ac    = 1'b0;
        o_ld_x     = 1'b0;
        o_ld_opl   = 1'b0;
        o_upd_nz   = 1'b0;
        o_upd_c    = 1'b0;
        o_set_c    = 1'b0;
        o_clr_c    = 1'b0;
        o_rw_next  = 1'b1;

        if (i_tcu == TCU_T0) begin
            // IR still holds the previous opcode here
            o_tcu_next = TCU_T1;
            o_pc_inc   = 1'b1;
        end else begin
            case (i_ir)
                `CPU_OP_LDA_IMM, `CPU_OP_LDX_IMM: begin
                    o_pc_inc = 1'b1;
                    o_ld_ac  = (i_ir == `CPU_OP_LDA_IMM);
                    o_ld_x   = (i_ir == `CPU_OP_LDX_IMM);
                    o_upd_nz = 1'b1;
                end
                `CPU_OP_ADC_IMM, `CPU_OP_AND_IMM, `CPU_OP_ORA_IMM, `CPU_OP_EOR_IMM: begin
                    o_pc_inc = 1'b1;
                    o_db_src = DB_ALU;
                    o_ld_ac  = 1'b1;
                    o_upd_nz = 1'b1;
                    // Only ADC consumes and produces the carry
                    o_upd_c  = (i_ir == `CPU_OP_ADC_IMM);
                    case (i_ir)
                        `CPU_OP_ADC_IMM: o_alu_op = ALU_SUM;
                        `CPU_OP_AND_IMM: o_alu_op = ALU_AND;
                        `CPU_OP_ORA_IMM: o_alu_op = ALU_OR;
                        default:         o_alu_op = ALU_EOR;
                    endcase
                end
                `CPU_OP_LSR_A: begin
                    // Bit 0 of AC leaves through the carry
                    o_adr_src = ADR_HOLD;
                    o_db_src  = DB_ALU;
                    o_alu_op  = ALU_SR;
                    o_ld_ac   = 1'b1;
                    o_upd_nz  = 1'b1;
                    o_upd_c   = 1'b1;
                end
                `CPU_OP_TAX, `CPU_OP_TXA: begin
                    o_adr_src = ADR_HOLD;
                    o_db_src  = (i_ir == `CPU_OP_TAX) ? DB_AC : DB_X;
                    o_ld_x    = (i_ir == `CPU_OP_TAX);
                    o_ld_ac   = (i_ir == `CPU_OP_TXA);
                    o_upd_nz  = 1'b1;
                end
                `CPU_OP_CLC, `CPU_OP_SEC: begin
                    o_adr_src = ADR_HOLD;
                    o_clr_c   = (i_ir == `CPU_OP_CLC);
                    o_set_c   = (i_ir == `CPU_OP_SEC);
                end
                `CPU_OP_LDA_ABS, `CPU_OP_STA_ABS, `CPU_OP_STX_ABS: begin
                    case (i_tcu)
                        TCU_T1: begin
                            o_tcu_next = TCU_T2;
                            o_pc_inc   = 1'b1;
                            o_ld_opl   = 1'b1;
                        end
                        TCU_T2: begin
                            // High byte on the bus completes the operand address
                            o_tcu_next = TCU_T3;
                            o_pc_inc   = 1'b1;
                            o_adr_src  = ADR_OP;
                            o_rw_next  = (i_ir == `CPU_OP_LDA_ABS);
                            o_db_src   = (i_ir == `CPU_OP_STX_ABS) ? DB_X : DB_AC;
                        end
                        default: begin
                            o_ld_ac  = (i_ir == `CPU_OP_LDA_ABS);
                            o_upd_nz = (i_ir == `CPU_OP_LDA_ABS);
                        end
                    endcase
                end
                `CPU_OP_JMP_ABS: begin
                    if (i_tcu == TCU_T1) begin
                        o_tcu_next = TCU_T2;
                        o_pc_inc   = 1'b1;
                        o_ld_opl   = 1'b1;
                    end else begin
                        o_pc_jump = 1'b1;
                    end
                end
                // NOP and unknown opcodes
                default: o_adr_src = ADR_HOLD;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/cpu_program_counter.sv
`timescale 1ns/1ns
`default_nettype none
`include "cpu_settings.svh"

module cpu_program_counter
    import cpu_bus_pkg::*;
(
    input  logic  i_clk,
    input  logic  i_rst_n,
    input  logic  i_inc,
    input  logic  i_jump,
    input  data_t i_opl,
    input  data_t i_oph,
    output addr_t o_pc
);

    addr_t pc_q;
    addr_t pc_next;

    always_comb begin
        pc_next = pc_q;
        if (i_jump) begin
            pc_next = {i_oph, i_opl};
        end else if (i_inc) begin
            pc_next = pc_q + 16'd1;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc_q <= `CPU_RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    // Updated value, so the address register can take it at the same edge
    assign o_pc = pc_next;

endmodule

`default_nettype wire

// File: design/cpu_alu.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_alu
    import cpu_bus_pkg::*, cpu_ctrl_pkg::*;
(
    input  data_t   i_a,
    input  data_t   i_b,
    input  alu_op_e i_op,
    input  logic    i_c,
    output data_t   o_result,
    output logic    o_c
);

    logic [8:0] sum;

    assign sum = {1'b0, i_a} + {1'b0, i_b} + {8'h00, i_c};

    always_comb begin
        o_result = i_b;
        o_c      = 1'b0;
        case (i_op)
            ALU_SUM: begin
                o_result = sum[7:0];
                o_c      = sum[8];
            end
            ALU_AND: o_result = i_a & i_b;
            ALU_EOR: o_result = i_a ^ i_b;
            ALU_OR:  o_result = i_a | i_b;
            ALU_SR: begin
                // Logical shift, zero into bit 7
                o_result = {1'b0, i_a[7:1]};
                o_c      = i_a[0];
            end
            default: o_result = i_b;
        endcase
    end

endmodule

`default_nettype wire

// File: design/cpu_status.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_status
    import cpu_bus_pkg::*;
(
    input  logic  i_clk,
    input  logic  i_rst_n,
    input  data_t i_value,
    input  logic  i_alu_c,
    input  logic  i_upd_nz,
    input  logic  i_upd_c,
    input  logic  i_set_c,
    input  logic  i_clr_c,
    output logic  o_c
);

    // N, Z and C in that order
    logic [2:0] flags_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            flags_q <= 3'b000;
        end else begin
            if (i_upd_nz) begin
                flags_q[2] <= i_value[7];
                flags_q[1] <= (i_value == 8'h00);
            end
            if (i_set_c) begin
                flags_q[0] <= 1'b1;
            end else if (i_clr_c) begin
                flags_q[0] <= 1'b0;
            end else if (i_upd_c) begin
                flags_q[0] <= i_alu_c;
            end
        end
    end

    assign o_c = flags_q[0];

endmodule

`default_nettype wire

// File: design/cpu_datapath.sv
`timescale 1ns/1ns
`default_nettype none
`include "cpu_settings.svh"

module cpu_datapath
    import cpu_bus_pkg::*, cpu_ctrl_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  data_t    i_data,
    input  db_src_e  i_db_src,
    input  data_t    i_alu_result,
    input  adr_src_e i_adr_src,
    input  addr_t    i_pc,
    input  logic     i_ld_ac,
    input  logic     i_ld_x,
    input  logic     i_ld_opl,
    input  logic     i_rw_next,
    output data_t    o_db,
    output data_t    o_ac,
    output data_t    o_opl,
    output data_t    o_oph,
    output addr_t    o_address,
    output logic     o_rw,
    output data_t    o_data
);

    data_t ac_q;
    data_t x_q;
    data_t opl_q;
    addr_t addr_next;

    // Internal data bus
    always_comb begin
        case (i_db_src)
            DB_AC:   o_db = ac_q;
            DB_X:    o_db = x_q;
            DB_ALU:  o_db = i_alu_result;
            default: o_db = i_data;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ac_q <= 8'h00;
            x_q  <= 8'h00;
        end else begin
            if (i_ld_ac) begin
                ac_q <= o_db;
            end
            if (i_ld_x) begin
                x_q <= o_db;
            end
        end
    end

    // Operand low byte, kept until the high byte arrives
    always_ff @(posedge i_clk) begin
        if (i_ld_opl) begin
            opl_q <= i_data;
        end
    end

    always_comb begin
        case (i_adr_src)
            ADR_PC:  addr_next = i_pc;
            ADR_OP:  addr_next = {i_data, opl_q};
            default: addr_next = o_address;
        endcase
    end

    // Bus outputs for the cycle that begins at this edge
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_address <= `CPU_RESET_PC;
            o_rw      <= 1'b1;
            o_data    <= 8'h00;
        end else begin
            o_address <= addr_next;
            o_rw      <= i_rw_next;
            if (!i_rw_next) begin
                o_data <= o_db;
            end
        end
    end

    assign o_ac  = ac_q;
    assign o_opl = opl_q;
    // High byte is taken straight from the data latch input
    assign o_oph = i_data;

endmodule

`default_nettype wire

// File: design/cpu_core.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_core
    import cpu_bus_pkg::*, cpu_ctrl_pkg::*;
(
    input  logic  i_clk,
    input  logic  i_rst_n,
    output logic  o_rw,
    output addr_t o_address,
    input  data_t i_data,
    output data_t o_data,
    output logic  o_sync
);

    tcu_e     w_tcu;
    tcu_e     w_tcu_next;
    data_t    w_ir;
    db_src_e  w_db_src;
    alu_op_e  w_alu_op;
    adr_src_e w_adr_src;
    logic     w_pc_inc;
    logic     w_pc_jump;
    logic     w_ld_ac;
    logic     w_ld_x;
    logic     w_ld_opl;
    logic     w_upd_nz;
    logic     w_upd_c;
    logic     w_set_c;
    logic     w_clr_c;
    logic     w_rw_next;
    addr_t    w_pc;
    data_t    w_db;
    data_t    w_ac;
    data_t    w_opl;
    data_t    w_oph;
    data_t    w_alu_result;
    logic     w_alu_c;
    logic     w_c;

    cpu_timing u_timing (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_data     (i_data),
        .i_tcu_next (w_tcu_next),
        .o_tcu      (w_tcu),
        .o_ir       (w_ir),
        .o_sync     (o_sync)
    );

    cpu_decoder u_decoder (
        .i_ir       (w_ir),
        .i_tcu      (w_tcu),
        .o_tcu_next (w_tcu_next),
        .o_db_src   (w_db_src),
        .o_alu_op   (w_alu_op),
        .o_adr_src  (w_adr_src),
        .o_pc_inc   (w_pc_inc),
        .o_pc_jump  (w_pc_jump),
        .o_ld_ac    (w_ld_ac),
        .o_ld_x     (w_ld_x),
        .o_ld_opl   (w_ld_opl),
        .o_upd_nz   (w_upd_nz),
        .o_upd_c    (w_upd_c),
        .o_set_c    (w_set_c),
        .o_clr_c    (w_clr_c),
        .o_rw_next  (w_rw_next)
    );

    cpu_program_counter u_pc (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_inc   (w_pc_inc),
        .i_jump  (w_pc_jump),
        .i_opl   (w_opl),
        .i_oph   (w_oph),
        .o_pc    (w_pc)
    );

    // Operand B is the byte arriving from memory
    cpu_alu u_alu (
        .i_a      (w_ac),
        .i_b      (i_data),
        .i_op     (w_alu_op),
        .i_c      (w_c),
        .o_result (w_alu_result),
        .o_c      (w_alu_c)
    );

    cpu_status u_status (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_value  (w_db),
        .i_alu_c  (w_alu_c),
        .i_upd_nz (w_upd_nz),
        .i_upd_c  (w_upd_c),
        .i_set_c  (w_set_c),
        .i_clr_c  (w_clr_c),
        .o_c      (w_c)
    );

    cpu_datapath u_datapath (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_data       (i_data),
        .i_db_src     (w_db_src),
        .i_alu_result (w_alu_result),
        .i_adr_src    (w_adr_src),
        .i_pc         (w_pc),
        .i_ld_ac      (w_ld_ac),
        .i_ld_x       (w_ld_x),
        .i_ld_opl     (w_ld_opl),
        .i_rw_next    (w_rw_next),
        .o_db         (w_db),
        .o_ac         (w_ac),
        .o_opl        (w_opl),
        .o_oph        (w_oph),
        .o_address    (o_address),
        .o_rw         (o_rw),
        .o_data       (o_data)
    );

endmodule

`default_nettype wire

// File: verif/cpu_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "cpu_settings.svh"

module cpu_tb
    import cpu_bus_pkg::*;
();

    localparam int          NUM_RANDOM = 300;
    // Closing self jump runs three times
    localparam int          NUM_STEPS  = NUM_RANDOM + 3;
    localparam int          WAIT_LIMIT = 8;
    localparam logic [31:0] LFSR_SEED  = 32'h4fb011e8;
    localparam data_t       DATA_PAGE  = 8'h30;

    logic  clk;
    logic  rst_n;
    logic  rw;
    addr_t address;
    data_t rdata;
    data_t wdata;
    logic  sync;

    data_t       mem [0:65535];
    data_t       ref_mem [0:65535];
    addr_t       ref_pc;
    data_t       ref_a;
    data_t       ref_x;
    logic        ref_c;
    logic        store_pending;
    addr_t       exp_addr;
    data_t       exp_data;
    int          exp_cycles;
    logic [31:0] lfsr_q;

    cpu_core u_dut (
        .i_clk     (clk),
        .i_rst_n   (rst_n),
        .o_rw      (rw),
        .o_address (address),
        .i_data    (rdata),
        .o_data    (wdata),
        .o_sync    (sync)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Memory answers reads at once and takes writes at the rising edge
    assign rdata = mem[address];

    always @(posedge clk) begin
        if (!rw) begin
            mem[address] = wdata;
        end
    end

    task automatic stop_with_failure;
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        $display("ERROR: %s", msg);
        stop_with_failure();
    endtask

    task automatic report_mismatch(input string name, input logic [15:0] exp,
                                   input logic [15:0] act);
        $display("MISMATCH %s expected=%h actual=%h", name, exp, act);
        stop_with_failure();
    endtask

    // Taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [15:0] v);
        v = 16'h0000;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[14:0], lfsr_q[0]};
        end
    endtask

    // Upper half of the range picks a store
    function automatic data_t pick_opcode(input logic [4:0] idx);
        if (idx[4]) begin
            return idx[0] ? `CPU_OP_STX_ABS : `CPU_OP_STA_ABS;
        end
        case (idx[3:0])
            4'd0:    return `CPU_OP_LDA_IMM;
            4'd1:    return `CPU_OP_LDX_IMM;
            4'd2:    return `CPU_OP_ADC_IMM;
            4'd3:    return `CPU_OP_AND_IMM;
            4'd4:    return `CPU_OP_ORA_IMM;
            4'd5:    return `CPU_OP_EOR_IMM;
            4'd6:    return `CPU_OP_LSR_A;
            4'd7:    return `CPU_OP_TAX;
            4'd8:    return `CPU_OP_TXA;
            4'd9:    return `CPU_OP_CLC;
            4'd10:   return `CPU_OP_SEC;
            4'd11:   return `CPU_OP_NOP;
            4'd12:   return `CPU_OP_LDA_ABS;
            4'd13:   return `CPU_OP_STA_ABS;
            4'd14:   return `CPU_OP_STX_ABS;
            default: return `CPU_OP_JMP_ABS;
        endcase
    endfunction

    task automatic put_byte(input addr_t a, input data_t d);
        mem[a] = d;
        ref_mem[a] = d;
    endtask

    task automatic fill_memory;
        addr_t a;
        for (int i = 0; i < 65536; i++) begin
            a = i[15:0];
            put_byte(a, a[15:8] ^ a[7:0] ^ 8'h5A);
        end
    endtask

    task automatic build_program;
        addr_t       ptr;
        addr_t       target;
        logic [15:0] r;
        data_t       op;
        lfsr_q = LFSR_SEED;
        ptr = `CPU_RESET_PC;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            draw_bits(5, r);
            op = pick_opcode(r[4:0]);
            draw_bits(8, r);
            put_byte(ptr, op);
            case (op)
                `CPU_OP_LDA_IMM, `CPU_OP_LDX_IMM, `CPU_OP_ADC_IMM, `CPU_OP_AND_IMM,
                `CPU_OP_ORA_IMM, `CPU_OP_EOR_IMM: begin
                    put_byte(ptr + 16'd1, r[7:0]);
                    ptr = ptr + 16'd2;
                end
                `CPU_OP_LDA_ABS, `CPU_OP_STA_ABS, `CPU_OP_STX_ABS: begin
                    // Sixteen data bytes, so loads often see earlier stores
                    put_byte(ptr + 16'd1, {4'h0, r[3:0]});
                    put_byte(ptr + 16'd2, DATA_PAGE);
                    ptr = ptr + 16'd3;
                end
                `CPU_OP_JMP_ABS: begin
                    // Forward over a few bytes that never run
                    target = ptr + 16'd3 + {13'd0, r[2:0]};
                    put_byte(ptr + 16'd1, target[7:0]);
                    put_byte(ptr + 16'd2, target[15:8]);
                    ptr = target;
                end
                default: ptr = ptr + 16'd1;
            endcase
        end
        put_byte(ptr, `CPU_OP_JMP_ABS);
        put_byte(ptr + 16'd1, ptr[7:0]);
        put_byte(ptr + 16'd2, ptr[15:8]);
    endtask

    // Bit 8 is the carry out
    function automatic logic [8:0] ref_alu(input data_t op, input data_t a, input data_t b,
                                           input logic c);
        int total;
        total = int'(a) + int'(b) + (c ? 1 : 0);
        case (op)
            `CPU_OP_ADC_IMM: return {total > 255, total[7:0]};
            `CPU_OP_AND_IMM: return {c, a & b};
            `CPU_OP_ORA_IMM: return {c, a | b};
            `CPU_OP_EOR_IMM: return {c, a ^ b};
            `CPU_OP_LSR_A:   return {a[0], a >> 1};
            default:         return {c, b};
        endcase
    endfunction

    task automatic ref_step;
        data_t      op;
        data_t      b1;
        addr_t      opnd;
        logic [8:0] res;
        op = ref_mem[ref_pc];
        b1 = ref_mem[ref_pc + 16'd1];
        opnd = {ref_mem[ref_pc + 16'd2], b1};
        store_pending = 1'b0;
        exp_cycles = 2;
        case (op)
            `CPU_OP_LDA_IMM: begin
                ref_a = b1;
                ref_pc = ref_pc + 16'd2;
            end
            `CPU_OP_LDX_IMM: begin
                ref_x = b1;
                ref_pc = ref_pc + 16'd2;
            end
            `CPU_OP_ADC_IMM, `CPU_OP_AND_IMM, `CPU_OP_ORA_IMM, `CPU_OP_EOR_IMM: begin
                res = ref_alu(op, ref_a, b1, ref_c);
                ref_a = res[7:0];
                ref_c = res[8];
                ref_pc = ref_pc + 16'd2;
            end
            `CPU_OP_LSR_A: begin
                res = ref_alu(op, ref_a, 8'h00, ref_c);
                ref_a = res[7:0];
                ref_c = res[8];
                ref_pc = ref_pc + 16'd1;
            end
            `CPU_OP_TAX, `CPU_OP_TXA, `CPU_OP_CLC, `CPU_OP_SEC: begin
                if (op == `CPU_OP_TAX) ref_x = ref_a;
                if (op == `CPU_OP_TXA) ref_a = ref_x;
                if (op == `CPU_OP_CLC) ref_c = 1'b0;
                if (op == `CPU_OP_SEC) ref_c = 1'b1;
                ref_pc = ref_pc + 16'd1;
            end
            `CPU_OP_LDA_ABS: begin
                ref_a = ref_mem[opnd];
                ref_pc = ref_pc + 16'd3;
                exp_cycles = 4;
            end
            `CPU_OP_STA_ABS, `CPU_OP_STX_ABS: begin
                store_pending = 1'b1;
                exp_addr = opnd;
                exp_data = (op == `CPU_OP_STA_ABS) ? ref_a : ref_x;
                ref_mem[opnd] = exp_data;
                ref_pc = ref_pc + 16'd3;
                exp_cycles = 4;
            end
            `CPU_OP_JMP_ABS: begin
                ref_pc = opnd;
                exp_cycles = 3;
            end
            default:         ref_pc = ref_pc + 16'd1;
        endcase
    endtask

    // Next cycle that is a fetch or a write, and how many clocks that took
    task automatic wait_bus_event(output int cycles);
        int n;
        n = 0;
        @(negedge clk);
        while (sync !== 1'b1 && rw !== 1'b0) begin
            n++;
            if (n > WAIT_LIMIT) begin
                report_error("timeout, no fetch or write cycle on the bus");
            end
            @(negedge clk);
        end
        cycles = n + 1;
    endtask

    initial begin
        int steps;
        int gap;
        int since_fetch;
        steps = 0;
        since_fetch = 0;
        rst_n <= 1'b0;
        fill_memory();
        build_program();
        ref_pc = `CPU_RESET_PC;
        ref_a = 8'h00;
        ref_x = 8'h00;
        ref_c = 1'b0;
        store_pending = 1'b0;
        exp_cycles = 0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        while (steps < NUM_STEPS) begin
            wait_bus_event(gap);
            since_fetch += gap;
            if (sync) begin
                if (steps == 0) begin
                    assert (wdata == 8'h00)
                        else report_mismatch("data output after reset", 16'h0000, {8'h00, wdata});
                end else begin
                    assert (since_fetch == exp_cycles)
                        else report_mismatch($sformatf("cycle count, step %0d", steps),
                                             exp_cycles[15:0], since_fetch[15:0]);
                end
                since_fetch = 0;
                assert (rw == 1'b1)
                    else report_error($sformatf("step %0d, fetch cycle is not a read", steps));
                assert (!store_pending)
                    else report_error($sformatf("step %0d, expected store never came", steps));
                assert (address == ref_pc)
                    else report_mismatch($sformatf("fetch address, step %0d", steps),
                                         ref_pc, address);
                ref_step();
                steps++;
            end else begin
                assert (store_pending)
                    else report_error($sformatf("step %0d, write cycle with no store", steps));
                assert (address == exp_addr)
                    else report_mismatch($sformatf("store address, step %0d", steps),
                                         exp_addr, address);
                assert (wdata == exp_data)
                    else report_mismatch($sformatf("store data, step %0d", steps),
                                         {8'h00, exp_data}, {8'h00, wdata});
                store_pending = 1'b0;
            end
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+design
design/cpu_bus_pkg.sv
design/cpu_ctrl_pkg.sv
design/cpu_timing.sv
design/cpu_decoder.sv
design/cpu_program_counter.sv
design/cpu_alu.sv
design/cpu_status.sv
design/cpu_datapath.sv
design/cpu_core.sv
verif/cpu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= sim.f
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
VFLAGS    ?= --binary --assert

SOURCES := $(wildcard design/*.sv design/*.svh verif/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "RESULT: PASS" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR)
